// File: core_top.f
+incdir+include
+incdir+testbench
src/core_isa_pkg.sv
src/core_pipe_pkg.sv
src/core_decode.sv
src/core_reg_file.sv
src/core_execute.sv
src/core_result.sv
src/core_top.sv
testbench/core_tb.sv

// File: include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath and address width
`define CORE_XLEN       32

// general purpose register file
`define CORE_NR_REGS    32
`define CORE_REG_W      5

// first fetch address out of reset
`define CORE_RESET_PC   32'h0000_0000

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 -f core_top.f --top-module core_tb -o core_tb_sim \
    && ./obj_dir/core_tb_sim > sim.log \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: src/core_decode.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  core_isa_pkg::inst_t       inst_i,
    input  logic                      inst_valid_i,
    input  logic                      advance_i,
    output logic [`CORE_XLEN-1:0]     pc_o,
    output core_pipe_pkg::dec_stage_t dec_o
);

    core_isa_pkg::inst_t        inst;
    logic [`CORE_XLEN-1:0]      pc_q;
    logic                       fwd_exec_vld_q;
    logic                       fwd_result_vld_q;
    logic [`CORE_REG_W-1:0]     fwd_exec_dst_q;
    logic [`CORE_REG_W-1:0]     fwd_result_dst_q;
    core_pipe_pkg::alu_op_e     alu_op;
    core_pipe_pkg::src_a_e      src_a_base;
    core_pipe_pkg::src_a_e      src_a;
    core_pipe_pkg::src_b_e      src_b_base;
    core_pipe_pkg::src_b_e      src_b;
    core_pipe_pkg::store_src_e  store_src;
    logic                       reg_wr;
    logic                       dst_rt;
    logic                       sign_ext;
    logic                       mem_rd;
    logic                       mem_we;
    logic [`CORE_REG_W-1:0]     a_idx;
    logic [`CORE_REG_W-1:0]     b_idx;
    logic [`CORE_REG_W-1:0]     dst;
    logic                       reg_we;
    logic [`CORE_XLEN-1:0]      imm;

    function automatic logic fwd_hit(input logic vld, input logic [`CORE_REG_W-1:0] dst_q,
                                     input logic [`CORE_REG_W-1:0] idx);
        return vld && (dst_q == idx) && (idx != '0);
    endfunction

    assign inst = inst_valid_i ? inst_i : '0;   // gap becomes sll r0,r0,0
    assign pc_o = pc_q;

    assign sign_ext = inst.opcode inside {core_isa_pkg::OP_ADDIU, core_isa_pkg::OP_SLTI,
                                          core_isa_pkg::OP_SLTIU, core_isa_pkg::OP_LW,
                                          core_isa_pkg::OP_SW};
    assign imm    = {{(`CORE_XLEN-16){sign_ext & inst[15]}}, inst[15:0]};
    assign dst    = dst_rt ? inst.rt : inst.rd;
    assign reg_we = reg_wr && (dst != '0);      // r0 writes dropped early

    always_comb begin
        alu_op     = core_pipe_pkg::ALU_ADD;
        src_a_base = core_pipe_pkg::A_ZERO;
        src_b_base = core_pipe_pkg::B_IMM;
        reg_wr     = 1'b0;
        dst_rt     = 1'b1;
        mem_rd     = 1'b0;
        mem_we     = 1'b0;
        case (inst.opcode)
            core_isa_pkg::OP_SPECIAL: begin
                src_a_base = core_pipe_pkg::A_RS;
                src_b_base = core_pipe_pkg::B_RT;
                reg_wr     = 1'b1;
                dst_rt     = 1'b0;
                case (inst.funct)
                    core_isa_pkg::F_SLL, core_isa_pkg::F_SLLV: alu_op = core_pipe_pkg::ALU_SLL;
                    core_isa_pkg::F_SRL, core_isa_pkg::F_SRLV: alu_op = core_pipe_pkg::ALU_SRL;
                    core_isa_pkg::F_SRA, core_isa_pkg::F_SRAV: alu_op = core_pipe_pkg::ALU_SRA;
                    core_isa_pkg::F_ADDU: alu_op = core_pipe_pkg::ALU_ADD;
                    core_isa_pkg::F_SUBU: alu_op = core_pipe_pkg::ALU_SUB;
                    core_isa_pkg::F_AND:  alu_op = core_pipe_pkg::ALU_AND;
                    core_isa_pkg::F_OR:   alu_op = core_pipe_pkg::ALU_OR;
                    core_isa_pkg::F_XOR:  alu_op = core_pipe_pkg::ALU_XOR;
                    core_isa_pkg::F_NOR:  alu_op = core_pipe_pkg::ALU_NOR;
                    core_isa_pkg::F_SLT:  alu_op = core_pipe_pkg::ALU_SLT;
                    core_isa_pkg::F_SLTU: alu_op = core_pipe_pkg::ALU_SLTU;
                    default:              reg_wr = 1'b0;
                endcase
                if (inst.funct[5:3] == 3'b000) begin    // shifts operate on rt
                    src_a_base = core_pipe_pkg::A_RT;
                    src_b_base = inst.funct[2] ? core_pipe_pkg::B_RS : core_pipe_pkg::B_SHAMT;
                end
            end
            core_isa_pkg::OP_ADDIU, core_isa_pkg::OP_SLTI, core_isa_pkg::OP_SLTIU,
            core_isa_pkg::OP_ANDI, core_isa_pkg::OP_ORI, core_isa_pkg::OP_XORI,
            core_isa_pkg::OP_LUI, core_isa_pkg::OP_LW: begin
                src_a_base = core_pipe_pkg::A_RS;
                reg_wr     = 1'b1;
                mem_rd     = (inst.opcode == core_isa_pkg::OP_LW);
            end
            core_isa_pkg::OP_SW: begin
                src_a_base = core_pipe_pkg::A_RS;
                mem_we     = 1'b1;
            end
            default: ;
        endcase
        case (inst.opcode)
            core_isa_pkg::OP_SLTI:  alu_op = core_pipe_pkg::ALU_SLT;
            core_isa_pkg::OP_SLTIU: alu_op = core_pipe_pkg::ALU_SLTU;
            core_isa_pkg::OP_ANDI:  alu_op = core_pipe_pkg::ALU_AND;
            core_isa_pkg::OP_ORI:   alu_op = core_pipe_pkg::ALU_OR;
            core_isa_pkg::OP_XORI:  alu_op = core_pipe_pkg::ALU_XOR;
            core_isa_pkg::OP_LUI:   alu_op = core_pipe_pkg::ALU_LUI;
            default: ;
        endcase
    end

    // younger producer wins over the older one
    always_comb begin
        a_idx     = (src_a_base == core_pipe_pkg::A_RT) ? inst.rt : inst.rs;
        b_idx     = (src_b_base == core_pipe_pkg::B_RS) ? inst.rs : inst.rt;
        src_a     = src_a_base;
        src_b     = src_b_base;
        store_src = core_pipe_pkg::ST_RT;
        if (src_a_base inside {core_pipe_pkg::A_RS, core_pipe_pkg::A_RT}) begin
            if (fwd_hit(fwd_exec_vld_q, fwd_exec_dst_q, a_idx))
                src_a = core_pipe_pkg::A_EXEC_FWD;
            else if (fwd_hit(fwd_result_vld_q, fwd_result_dst_q, a_idx))
                src_a = core_pipe_pkg::A_RESULT_FWD;
        end
        if (src_b_base inside {core_pipe_pkg::B_RS, core_pipe_pkg::B_RT}) begin
            if (fwd_hit(fwd_exec_vld_q, fwd_exec_dst_q, b_idx))
                src_b = core_pipe_pkg::B_EXEC_FWD;
            else if (fwd_hit(fwd_result_vld_q, fwd_result_dst_q, b_idx))
                src_b = core_pipe_pkg::B_RESULT_FWD;
        end
        if (fwd_hit(fwd_exec_vld_q, fwd_exec_dst_q, inst.rt))
            store_src = core_pipe_pkg::ST_EXEC_FWD;
        else if (fwd_hit(fwd_result_vld_q, fwd_result_dst_q, inst.rt))
            store_src = core_pipe_pkg::ST_RESULT_FWD;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q             <= `CORE_RESET_PC;
            dec_o            <= '0;
            fwd_exec_vld_q   <= 1'b0;
            fwd_exec_dst_q   <= '0;
            fwd_result_vld_q <= 1'b0;
            fwd_result_dst_q <= '0;
        end else if (advance_i) begin
            if (inst_valid_i)
                pc_q <= pc_q + `CORE_XLEN'd4;
            dec_o.rs         <= inst.rs;
            dec_o.rt         <= inst.rt;
            dec_o.imm        <= imm;
            dec_o.shamt      <= inst.shamt;
            dec_o.alu_op     <= alu_op;
            dec_o.src_a      <= src_a;
            dec_o.src_b      <= src_b;
            dec_o.store_src  <= store_src;
            dec_o.dst        <= dst;
            dec_o.reg_we     <= reg_we;
            dec_o.mem_rd     <= mem_rd;
            dec_o.mem_we     <= mem_we;
            fwd_exec_vld_q   <= reg_we;
            fwd_exec_dst_q   <= dst;
            fwd_result_vld_q <= fwd_exec_vld_q;  // ages into result stage
            fwd_result_dst_q <= fwd_exec_dst_q;
        end
    end

endmodule

// File: src/core_execute.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_execute (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       advance_i,
    input  core_pipe_pkg::dec_stage_t  dec_i,
    input  logic [`CORE_XLEN-1:0]      rs_data_i,
    input  logic [`CORE_XLEN-1:0]      rt_data_i,
    input  logic [`CORE_XLEN-1:0]      result_fwd_i,
    output core_pipe_pkg::exec_stage_t exec_o
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] store_data;
    logic [`CORE_XLEN-1:0] alu_res;

    always_comb begin
        case (dec_i.src_a)
            core_pipe_pkg::A_RS:         op_a = rs_data_i;
            core_pipe_pkg::A_RT:         op_a = rt_data_i;
            core_pipe_pkg::A_EXEC_FWD:   op_a = exec_o.result;
            core_pipe_pkg::A_RESULT_FWD: op_a = result_fwd_i;
            default:                     op_a = '0;
        endcase
    end

    always_comb begin
        case (dec_i.src_b)
            core_pipe_pkg::B_RT:         op_b = rt_data_i;
            core_pipe_pkg::B_IMM:        op_b = dec_i.imm;
            core_pipe_pkg::B_SHAMT:      op_b = `CORE_XLEN'(dec_i.shamt);
            core_pipe_pkg::B_EXEC_FWD:   op_b = exec_o.result;
            core_pipe_pkg::B_RESULT_FWD: op_b = result_fwd_i;
            core_pipe_pkg::B_RS:         op_b = rs_data_i;
            default:                     op_b = '0;
        endcase
    end

    // sw data is rt, possibly still in flight
    always_comb begin
        case (dec_i.store_src)
            core_pipe_pkg::ST_EXEC_FWD:   store_data = exec_o.result;
            core_pipe_pkg::ST_RESULT_FWD: store_data = result_fwd_i;
            default:                      store_data = rt_data_i;
        endcase
    end

    always_comb begin
        case (dec_i.alu_op)
            core_pipe_pkg::ALU_ADD:  alu_res = op_a + op_b;
            core_pipe_pkg::ALU_SUB:  alu_res = op_a - op_b;
            core_pipe_pkg::ALU_AND:  alu_res = op_a & op_b;
            core_pipe_pkg::ALU_OR:   alu_res = op_a | op_b;
            core_pipe_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            core_pipe_pkg::ALU_NOR:  alu_res = ~(op_a | op_b);
            core_pipe_pkg::ALU_SLT:  alu_res = `CORE_XLEN'($signed(op_a) < $signed(op_b));
            core_pipe_pkg::ALU_SLTU: alu_res = `CORE_XLEN'(op_a < op_b);
            core_pipe_pkg::ALU_SLL:  alu_res = op_a << op_b[4:0];
            core_pipe_pkg::ALU_SRL:  alu_res = op_a >> op_b[4:0];
            core_pipe_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            core_pipe_pkg::ALU_LUI:  alu_res = {op_b[15:0], {(`CORE_XLEN-16){1'b0}}};
            default:                 alu_res = '0;
        endcase
    end

    // held while the bus stalls, so the request stays stable
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_o <= '0;
        end else if (advance_i) begin
            exec_o.result     <= alu_res;    // also the load/store address
            exec_o.store_data <= store_data;
            exec_o.dst        <= dec_i.dst;
            exec_o.reg_we     <= dec_i.reg_we;
            exec_o.mem_rd     <= dec_i.mem_rd;
            exec_o.mem_we     <= dec_i.mem_we;
        end
    end

endmodule

// File: src/core_isa_pkg.sv
`include "core_cfg.svh"

package core_isa_pkg;

    // primary opcodes, anything else decodes as a no-op
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [`CORE_REG_W-1:0] rs;
        logic [`CORE_REG_W-1:0] rt;
        logic [`CORE_REG_W-1:0] rd;   // imm is rd, shamt, funct
        logic [4:0]             shamt;
        funct_e                 funct;
    } inst_t;

endpackage

// File: src/core_pipe_pkg.sv
`include "core_cfg.svh"

package core_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_NOR  = 4'h5,
        ALU_SLT  = 4'h6,
        ALU_SLTU = 4'h7,
        ALU_SLL  = 4'h8,
        ALU_SRL  = 4'h9,
        ALU_SRA  = 4'ha,
        ALU_LUI  = 4'hb
    } alu_op_e;

    typedef enum logic [2:0] {
        A_RS         = 3'h0,
        A_RT         = 3'h1,
        A_EXEC_FWD   = 3'h2,
        A_RESULT_FWD = 3'h3,
        A_ZERO       = 3'h4
    } src_a_e;

    typedef enum logic [2:0] {
        B_RT         = 3'h0,
        B_IMM        = 3'h1,
        B_SHAMT      = 3'h2,
        B_EXEC_FWD   = 3'h3,
        B_RESULT_FWD = 3'h4,
        B_RS         = 3'h5
    } src_b_e;

    typedef enum logic [1:0] {
        ST_RT         = 2'h0,
        ST_EXEC_FWD   = 2'h1,
        ST_RESULT_FWD = 2'h2
    } store_src_e;

    // decode -> execute
    typedef struct packed {
        logic [`CORE_REG_W-1:0] rs;
        logic [`CORE_REG_W-1:0] rt;
        logic [`CORE_XLEN-1:0]  imm;
        logic [4:0]             shamt;
        alu_op_e                alu_op;
        src_a_e                 src_a;
        src_b_e                 src_b;
        store_src_e             store_src;
        logic [`CORE_REG_W-1:0] dst;
        logic                   reg_we;
        logic                   mem_rd;
        logic                   mem_we;
    } dec_stage_t;

    // execute -> result, also the data bus request
    typedef struct packed {
        logic [`CORE_XLEN-1:0]  result;
        logic [`CORE_XLEN-1:0]  store_data;
        logic [`CORE_REG_W-1:0] dst;
        logic                   reg_we;
        logic                   mem_rd;
        logic                   mem_we;
    } exec_stage_t;

    typedef struct packed {
        logic                   we;
        logic [`CORE_REG_W-1:0] dst;
        logic [`CORE_XLEN-1:0]  data;
    } wb_t;

endpackage

// File: src/core_reg_file.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CORE_REG_W-1:0] rs_addr_i,
    input  logic [`CORE_REG_W-1:0] rt_addr_i,
    output logic [`CORE_XLEN-1:0]  rs_data_o,
    output logic [`CORE_XLEN-1:0]  rt_data_o,
    input  core_pipe_pkg::wb_t     wb_i
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NR_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.dst != '0)) begin   // r0 stays zero
            regs[wb_i.dst] <= wb_i.data;
        end
    end

    // async read, forwarding covers the in-flight writers
    assign rs_data_o = regs[rs_addr_i];
    assign rt_data_o = regs[rt_addr_i];

endmodule

// File: src/core_result.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_result (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       advance_i,
    input  core_pipe_pkg::exec_stage_t exec_i,
    input  logic [`CORE_XLEN-1:0]      load_data_i,
    output core_pipe_pkg::wb_t         wb_o
);

    logic [`CORE_XLEN-1:0] wb_data;

    // load data is only valid on the edge the access completes
    assign wb_data = exec_i.mem_rd ? load_data_i : exec_i.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_o <= '0;
        end else if (advance_i) begin
            wb_o.we   <= exec_i.reg_we;
            wb_o.dst  <= exec_i.dst;
            wb_o.data <= wb_data;   // also the older forwarding source
        end
    end

endmodule

// File: src/core_top.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top (
    input  logic                  clk,
    input  logic                  rst,

    output logic [`CORE_XLEN-1:0] inst_addr_o,
    input  core_isa_pkg::inst_t   inst_data_i,
    input  logic                  inst_valid_i,

    output logic [`CORE_XLEN-1:0] data_addr_o,
    output logic [`CORE_XLEN-1:0] data_wdata_o,
    input  logic [`CORE_XLEN-1:0] data_rdata_i,
    output logic                  data_rd_o,
    output logic                  data_we_o,
    input  logic                  data_valid_i
);

    core_pipe_pkg::dec_stage_t  dec;
    core_pipe_pkg::exec_stage_t exec;
    core_pipe_pkg::wb_t         wb;
    logic [`CORE_XLEN-1:0]      rs_data;
    logic [`CORE_XLEN-1:0]      rt_data;

    core_decode core_decode_inst (
        .clk          (clk),
        .rst          (rst),
        .inst_i       (inst_data_i),
        .inst_valid_i (inst_valid_i),
        .advance_i    (data_valid_i),   // global stall
        .pc_o         (inst_addr_o),
        .dec_o        (dec)
    );

    core_reg_file core_reg_file_inst (
        .clk       (clk),
        .rst       (rst),
        .rs_addr_i (dec.rs),
        .rt_addr_i (dec.rt),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wb_i      (wb)
    );

    core_execute core_execute_inst (
        .clk          (clk),
        .rst          (rst),
        .advance_i    (data_valid_i),
        .dec_i        (dec),
        .rs_data_i    (rs_data),
        .rt_data_i    (rt_data),
        .result_fwd_i (wb.data),
        .exec_o       (exec)
    );

    core_result core_result_inst (
        .clk         (clk),
        .rst         (rst),
        .advance_i   (data_valid_i),
        .exec_i      (exec),
        .load_data_i (data_rdata_i),
        .wb_o        (wb)
    );

    assign data_addr_o  = exec.result;
    assign data_wdata_o = exec.store_data;
    assign data_rd_o    = exec.mem_rd;
    assign data_we_o    = exec.mem_we;

endmodule

// File: testbench/core_tb_model.svh
`ifndef CORE_TB_MODEL_SVH
`define CORE_TB_MODEL_SVH

logic [`CORE_XLEN-1:0] mdl_regs [`CORE_NR_REGS];
logic [`CORE_XLEN-1:0] mdl_mem [64];
logic [`CORE_XLEN-1:0] exp_addr_q [$];
logic [`CORE_XLEN-1:0] exp_data_q [$];
logic [`CORE_XLEN-1:0] exp_ld_addr_q [$];

function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
endfunction

// odd multiplier gives every word index its own value
function automatic logic [`CORE_XLEN-1:0] fill_word(int idx);
    return `CORE_XLEN'(idx) * 32'h9e37_79b1 ^ 32'h00c0_ffee;
endfunction

// recent destinations are favoured to hit both forwarding paths
function automatic logic [4:0] pick_src(logic [4:0] rec_a, logic [4:0] rec_b);
    case (rand_below(4))
        0:       return rec_a;
        1:       return rec_b;
        default: return 5'(rand_below(32));
    endcase
endfunction

function automatic logic [4:0] pick_dst();
    return (rand_below(16) == 0) ? 5'd0 : 5'(2 + rand_below(30));   // r1 kept as base
endfunction

task automatic make_inst(input logic [4:0] rec_a, input logic [4:0] rec_b,
                         input logic [15:0] sw_off, output logic [31:0] w,
                         output logic [4:0] dst, output logic is_load);
    int                     kind;
    logic [4:0]             rs;
    logic [4:0]             rt;
    logic [15:0]            imm;
    logic [15:0]            off;
    core_isa_pkg::opcode_e  op;
    core_isa_pkg::funct_e   fn;
    kind    = rand_below(100);
    rs      = pick_src(rec_a, rec_b);
    rt      = pick_src(rec_a, rec_b);
    dst     = pick_dst();
    imm     = 16'(rand_below(65536));
    off     = 16'(rand_below(64) * 4 - 128);    // base 0x80 keeps it in 0..0xfc
    is_load = 1'b0;
    if (kind < 18) begin
        dst = 5'd0;
        w   = {core_isa_pkg::OP_SW, 5'd1, rt, off};
    end else if (kind < 30) begin
        is_load = 1'b1;
        w       = {core_isa_pkg::OP_LW, 5'd1, dst, (rand_below(2) == 0) ? sw_off : off};
    end else if (kind < 60) begin
        case (rand_below(7))
            0:       op = core_isa_pkg::OP_ADDIU;
            1:       op = core_isa_pkg::OP_SLTI;
            2:       op = core_isa_pkg::OP_SLTIU;
            3:       op = core_isa_pkg::OP_ANDI;
            4:       op = core_isa_pkg::OP_ORI;
            5:       op = core_isa_pkg::OP_XORI;
            default: op = core_isa_pkg::OP_LUI;
        endcase
        w = {op, rs, dst, imm};
    end else begin
        case (rand_below(14))
            0:       fn = core_isa_pkg::F_SLL;
            1:       fn = core_isa_pkg::F_SRL;
            2:       fn = core_isa_pkg::F_SRA;
            3:       fn = core_isa_pkg::F_SLLV;
            4:       fn = core_isa_pkg::F_SRLV;
            5:       fn = core_isa_pkg::F_SRAV;
            6:       fn = core_isa_pkg::F_ADDU;
            7:       fn = core_isa_pkg::F_SUBU;
            8:       fn = core_isa_pkg::F_AND;
            9:       fn = core_isa_pkg::F_OR;
            10:      fn = core_isa_pkg::F_XOR;
            11:      fn = core_isa_pkg::F_NOR;
            12:      fn = core_isa_pkg::F_SLT;
            default: fn = core_isa_pkg::F_SLTU;
        endcase
        w = {core_isa_pkg::OP_SPECIAL, rs, rt, dst, 5'(rand_below(32)), fn};
    end
endtask

task automatic build_program();
    logic [31:0] w;
    logic [4:0]  dst;
    logic        is_load;
    logic [4:0]  ld_dst;
    logic [4:0]  rec_a;
    logic [4:0]  rec_b;
    logic [15:0] sw_off;
    ld_dst  = 5'd0;
    rec_a   = 5'd2;
    rec_b   = 5'd3;
    sw_off  = 16'h0000;
    prog[0] = {core_isa_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0080};    // data base in r1
    for (int k = 1; k < NR_WORDS; k++) begin
        // no read of a load destination in the very next slot
        do begin
            make_inst(rec_a, rec_b, sw_off, w, dst, is_load);
        end while (ld_dst != 5'd0 && (w[25:21] == ld_dst || w[20:16] == ld_dst));
        prog[k] = w;
        ld_dst  = is_load ? dst : 5'd0;
        if (w[31:26] == core_isa_pkg::OP_SW)
            sw_off = w[15:0];
        if (dst != 5'd0) begin
            rec_b = rec_a;
            rec_a = dst;
        end
    end
    for (int k = NR_WORDS; k < 512; k++) begin
        prog[k] = '0;
    end
endtask

task automatic run_model();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] zimm;
    logic [31:0] addr;
    logic [31:0] v;
    logic [4:0]  sh;
    logic [4:0]  dst;
    logic        wr;
    for (int i = 0; i < 64; i++) begin
        mdl_mem[i] = fill_word(i);
    end
    for (int r = 0; r < `CORE_NR_REGS; r++) begin
        mdl_regs[r] = '0;
    end
    for (int k = 0; k < NR_WORDS; k++) begin
        w    = prog[k];
        a    = mdl_regs[w[25:21]];
        b    = mdl_regs[w[20:16]];
        sh   = w[10:6];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0000, w[15:0]};
        addr = a + simm;
        dst  = w[20:16];
        wr   = 1'b1;
        v    = '0;
        case (w[31:26])
            core_isa_pkg::OP_SPECIAL: begin
                dst = w[15:11];
                case (w[5:0])
                    core_isa_pkg::F_SLL:  v = b << sh;
                    core_isa_pkg::F_SRL:  v = b >> sh;
                    core_isa_pkg::F_SRA:  v = $signed(b) >>> sh;
                    core_isa_pkg::F_SLLV: v = b << a[4:0];
                    core_isa_pkg::F_SRLV: v = b >> a[4:0];
                    core_isa_pkg::F_SRAV: v = $signed(b) >>> a[4:0];
                    core_isa_pkg::F_ADDU: v = a + b;
                    core_isa_pkg::F_SUBU: v = a - b;
                    core_isa_pkg::F_AND:  v = a & b;
                    core_isa_pkg::F_OR:   v = a | b;
                    core_isa_pkg::F_XOR:  v = a ^ b;
                    core_isa_pkg::F_NOR:  v = ~(a | b);
                    core_isa_pkg::F_SLT:  v = {31'h0, $signed(a) < $signed(b)};
                    core_isa_pkg::F_SLTU: v = {31'h0, a < b};
                    default:              wr = 1'b0;
                endcase
            end
            core_isa_pkg::OP_ADDIU: v = a + simm;
            core_isa_pkg::OP_SLTI:  v = {31'h0, $signed(a) < $signed(simm)};
            core_isa_pkg::OP_SLTIU: v = {31'h0, a < simm};   // compare against sign-extended imm
            core_isa_pkg::OP_ANDI:  v = a & zimm;
            core_isa_pkg::OP_ORI:   v = a | zimm;
            core_isa_pkg::OP_XORI:  v = a ^ zimm;
            core_isa_pkg::OP_LUI:   v = {w[15:0], 16'h0000};
            core_isa_pkg::OP_LW: begin
                v = mdl_mem[addr[7:2]];
                exp_ld_addr_q.push_back(addr);
            end
            core_isa_pkg::OP_SW: begin
                wr = 1'b0;
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(b);
                mdl_mem[addr[7:2]] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0)
            mdl_regs[dst] = v;
    end
endtask

`endif

// File: testbench/core_tb.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_tb;

    localparam int PROG_LEN   = 400;
    localparam int NR_WORDS   = PROG_LEN + 1;   // plus the base setup
    localparam int RST_CYCLES = 16;
    localparam int DRAIN      = 6;
    localparam int TIMEOUT_NS = (RST_CYCLES + NR_WORDS * 20) * 4;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [`CORE_XLEN-1:0] inst_addr_o;
    core_isa_pkg::inst_t   inst_data_i;
    logic                  inst_valid_i;
    logic [`CORE_XLEN-1:0] data_addr_o;
    logic [`CORE_XLEN-1:0] data_wdata_o;
    logic [`CORE_XLEN-1:0] data_rdata_i;
    logic                  data_rd_o;
    logic                  data_we_o;
    logic                  data_valid_i;

    int                    seed = 32'h828371c1;
    logic [31:0]           prog [512];
    logic [`CORE_XLEN-1:0] dmem [64];
    logic [`CORE_XLEN-1:0] pc_exp;
    int                    mismatch_cnt;
    int                    fault_cnt;
    int                    store_cnt;
    int                    load_cnt;
    int                    drain_cnt;

    `include "core_tb_model.svh"

    core_top core_top_inst (.*);

    always #2 clk = ~clk;

    task automatic check_pc(input string name, input logic [`CORE_XLEN-1:0] exp,
                            input logic [`CORE_XLEN-1:0] act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_store(input int idx, input logic [`CORE_XLEN-1:0] exp_addr,
                               input logic [`CORE_XLEN-1:0] exp_data,
                               input logic [`CORE_XLEN-1:0] act_addr,
                               input logic [`CORE_XLEN-1:0] act_data);
        if (act_addr !== exp_addr) begin
            mismatch_cnt++;
            $display("MISMATCH store %0d addr: expected %h actual %h", idx, exp_addr, act_addr);
        end
        if (act_data !== exp_data) begin
            mismatch_cnt++;
            $display("MISMATCH store %0d data: expected %h actual %h", idx, exp_data, act_data);
        end
    endtask

    task automatic check_load(input int idx, input logic [`CORE_XLEN-1:0] exp_addr,
                              input logic [`CORE_XLEN-1:0] act_addr);
        if (act_addr !== exp_addr) begin
            mismatch_cnt++;
            $display("MISMATCH load %0d addr: expected %h actual %h", idx, exp_addr, act_addr);
        end
    endtask

    task automatic report_fault(input string what);
        fault_cnt++;
        $display("ERROR: %s", what);
    endtask

    task automatic drive_inputs();
        logic in_prog;
        in_prog      = inst_addr_o < `CORE_XLEN'(NR_WORDS * 4);
        data_valid_i = (rand_below(5) != 0);    // ~20% stall
        inst_valid_i = in_prog && (rand_below(10) != 0);
        inst_data_i  = core_isa_pkg::inst_t'(in_prog ? prog[inst_addr_o[10:2]] : 32'h0);
        data_rdata_i = dmem[data_addr_o[7:2]];
    endtask

    // registered outputs still hold the values of the last cycle here
    task automatic sample_edge();
        check_pc("pc", pc_exp, inst_addr_o);
        if (data_valid_i && inst_valid_i)
            pc_exp = pc_exp + `CORE_XLEN'd4;
        if (data_valid_i && data_we_o) begin
            if (exp_addr_q.size() == 0) begin
                report_fault("store on the bus when no store was expected");
            end else begin
                check_store(store_cnt, exp_addr_q.pop_front(), exp_data_q.pop_front(),
                            data_addr_o, data_wdata_o);
            end
            store_cnt++;
            dmem[data_addr_o[7:2]] = data_wdata_o;
        end
        if (data_valid_i && data_rd_o) begin
            if (exp_ld_addr_q.size() == 0)
                report_fault("load on the bus when no load was expected");
            else
                check_load(load_cnt, exp_ld_addr_q.pop_front(), data_addr_o);
            load_cnt++;
        end
        if (data_valid_i && pc_exp == `CORE_XLEN'(NR_WORDS * 4))
            drain_cnt++;
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d stores and %0d loads seen",
                 mismatch_cnt, fault_cnt, store_cnt, load_cnt);
    endtask

    initial begin
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_data_i  = '0;
        data_valid_i = 1'b1;
        data_rdata_i = '0;
        pc_exp       = `CORE_RESET_PC;
        mismatch_cnt = 0;
        fault_cnt    = 0;
        store_cnt    = 0;
        load_cnt     = 0;
        drain_cnt    = 0;
        build_program();
        run_model();
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i);
        end
        for (int c = 0; c < RST_CYCLES; c++) begin
            @(posedge clk);
            if (c > 0) begin    // first edge loads the reset values
                check_pc("reset pc", `CORE_RESET_PC, inst_addr_o);
                if (data_we_o !== 1'b0 || data_rd_o !== 1'b0)
                    report_fault("bus request active during reset");
            end
        end
        #1;
        rst = 1'b0;
        drive_inputs();
        while (drain_cnt < DRAIN) begin
            @(posedge clk);
            sample_edge();
            #1;
            drive_inputs();
        end
        if (exp_addr_q.size() != 0)
            report_fault($sformatf("%0d expected stores never reached the bus",
                                   exp_addr_q.size()));
        if (exp_ld_addr_q.size() != 0)
            report_fault($sformatf("%0d expected loads never reached the bus",
                                   exp_ld_addr_q.size()));
        print_counts();
        if (mismatch_cnt + fault_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog allows 20 cycles per instruction
    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: run did not finish within %0d ns, %0d stores still expected",
                 TIMEOUT_NS, exp_addr_q.size());
        print_counts();
        $display("Checks failed");
        $finish;
    end

endmodule
